//--- source/pktgen_pkg.sv
// Shared widths, control register map, flow definition layout
// and framer FSM states for the packet generator
package pktgen_pkg;

    // Control port
    localparam int DATA_W         = 32;
    localparam int ADDR_W         = 5;

    // Output stream and flow table
    localparam int BEAT_BYTES     = 8;
    localparam int MAX_FLOWS      = 16;
    localparam int FLOW_ID_W      = 4;
    localparam int LEN_W          = 14;
    localparam int TX_CNT_W       = 28;
    localparam int CNT_W          = 64;

    // Staging words per flow definition, and their index width
    localparam int FLOW_DEF_WORDS = 5;
    localparam int WORD_IDX_W     = 3;

    // Ethernet header is DA, SA, EtherType
    localparam int HDR_BYTES      = 14;
    localparam int HDR_IDX_W      = 4;

    localparam logic [DATA_W-1:0] PKTGEN_ID = 32'h5047_0001;

    typedef struct packed {
        logic [47:0]      mac_da;
        logic [47:0]      mac_sa;
        logic [15:0]      ether_type;
        logic [LEN_W-1:0] pkt_len;
        logic [7:0]       payload_value;
    } flow_def_t;

    localparam int FLOW_DEF_BITS = $bits(flow_def_t);

    typedef enum logic [ADDR_W-1:0] {
        ADDR_ID,
        ADDR_TX_CON,
        ADDR_FLOW_CON,
        ADDR_CNTR_CON,
        ADDR_PKT_CNT0,
        ADDR_PKT_CNT1,
        ADDR_BYTE_CNT0,
        ADDR_BYTE_CNT1,
        ADDR_FLOW_DATA0,
        ADDR_FLOW_DATA1,
        ADDR_FLOW_DATA2,
        ADDR_FLOW_DATA3,
        ADDR_FLOW_DATA4
    } reg_addr_e;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        HEADER,
        PAYLOAD
    } framer_state_e;

endpackage

//--- source/pktgen_regs.sv
// Control port register block with flow staging words,
// commit and sample pulses and registered readback
`timescale 1ns/1ps

module pktgen_regs
    import pktgen_pkg::*;
(
    input  logic                 avmm_clk_ifc,
    input  logic                 rst_n,
    input  logic [ADDR_W-1:0]    address,
    input  logic                 write,
    input  logic [DATA_W-1:0]    writedata,
    input  logic                 read,
    output logic [DATA_W-1:0]    readdata,
    output logic                 readdatavalid,
    output logic                 tx_enable,
    output logic                 tx_finite,
    output logic [TX_CNT_W-1:0]  tx_count,
    output logic [FLOW_ID_W-1:0] last_flow,
    output logic                 flow_wr,
    output logic [FLOW_ID_W-1:0] flow_wr_id,
    output flow_def_t            flow_wr_data,
    output logic                 cnt_sample,
    input  logic [CNT_W-1:0]     pkt_snap,
    input  logic [CNT_W-1:0]     byte_snap
);

    logic [DATA_W-1:0]                flow_words [FLOW_DEF_WORDS];
    logic [FLOW_DEF_WORDS*DATA_W-1:0] stage_vec;
    logic                             is_flow_data;
    logic [WORD_IDX_W-1:0]            word_idx;
    logic [DATA_W-1:0]                rd_mux;

    assign is_flow_data = (address >= ADDR_FLOW_DATA0) && (address <= ADDR_FLOW_DATA4);
    assign word_idx     = WORD_IDX_W'(address - ADDR_FLOW_DATA0);

    ////////////////////////////////////////
    // Control registers and pulses
    ////////////////////////////////////////

    always_ff @(posedge avmm_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            tx_enable  <= 1'b0;
            tx_finite  <= 1'b0;
            tx_count   <= '0;
            last_flow  <= '0;
            flow_wr    <= 1'b0;
            flow_wr_id <= '0;
            cnt_sample <= 1'b0;
        end else begin
            flow_wr    <= 1'b0;
            cnt_sample <= 1'b0;
            if (write) begin
                case (address)
                    ADDR_TX_CON: begin
                        tx_enable <= writedata[0];
                        tx_finite <= writedata[1];
                        tx_count  <= writedata[31:4];
                    end
                    ADDR_FLOW_CON: begin
                        last_flow <= writedata[19:16];
                        if (writedata[0]) begin
                            flow_wr    <= 1'b1;
                            flow_wr_id <= writedata[11:8];
                        end
                    end
                    ADDR_CNTR_CON: cnt_sample <= writedata[0];
                    default: ;
                endcase
            end
        end
    end

    // Staging words, word 0 is the top of the definition
    always_ff @(posedge avmm_clk_ifc) begin
        if (write && is_flow_data) begin
            flow_words[word_idx] <= writedata;
        end
    end

    always_comb begin
        for (int i = 0; i < FLOW_DEF_WORDS; i++) begin
            stage_vec[DATA_W*(FLOW_DEF_WORDS-1-i) +: DATA_W] = flow_words[i];
        end
    end

    assign flow_wr_data = flow_def_t'(stage_vec >> (FLOW_DEF_WORDS*DATA_W - FLOW_DEF_BITS));

    ////////////////////////////////////////
    // Readback
    ////////////////////////////////////////

    always_comb begin
        rd_mux = '0;
        case (address)
            ADDR_ID:        rd_mux = PKTGEN_ID;
            ADDR_TX_CON:    rd_mux = {tx_count, 2'b00, tx_finite, tx_enable};
            ADDR_FLOW_CON:  rd_mux = {12'h000, last_flow, 4'h0, flow_wr_id, 8'h00};
            ADDR_PKT_CNT0:  rd_mux = pkt_snap[DATA_W-1:0];
            ADDR_PKT_CNT1:  rd_mux = pkt_snap[CNT_W-1:DATA_W];
            ADDR_BYTE_CNT0: rd_mux = byte_snap[DATA_W-1:0];
            ADDR_BYTE_CNT1: rd_mux = byte_snap[CNT_W-1:DATA_W];
            default: begin
                if (is_flow_data) begin
                    rd_mux = flow_words[word_idx];
                end
            end
        endcase
    end

    always_ff @(posedge avmm_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            readdata      <= '0;
            readdatavalid <= 1'b0;
        end else begin
            readdatavalid <= read;
            if (read) begin
                readdata <= rd_mux;
            end
        end
    end

    // Host never issues both strobes in one cycle
    assert property (@(posedge avmm_clk_ifc) disable iff (!rst_n) !(read && write))
        else $error("read and write strobes in the same cycle");

endmodule

//--- source/pktgen_flow_table.sv
// Flow definition memory, one write port and one registered read port
`timescale 1ns/1ps

module pktgen_flow_table
    import pktgen_pkg::*;
(
    input  logic                 avmm_clk_ifc,
    input  logic                 flow_wr,
    input  logic [FLOW_ID_W-1:0] flow_wr_id,
    input  flow_def_t            flow_wr_data,
    input  logic [FLOW_ID_W-1:0] flow_id,
    output flow_def_t            flow_rd_data
);

    flow_def_t mem [MAX_FLOWS];

    always_ff @(posedge avmm_clk_ifc) begin
        if (flow_wr) begin
            mem[flow_wr_id] <= flow_wr_data;
        end
    end

    // Read data lags the address by one cycle
    always_ff @(posedge avmm_clk_ifc) begin
        flow_rd_data <= mem[flow_id];
    end

endmodule

//--- source/pktgen_scheduler.sv
// Round-robin flow scheduler with finite or continuous packet budget
`timescale 1ns/1ps

module pktgen_scheduler
    import pktgen_pkg::*;
(
    input  logic                 avmm_clk_ifc,
    input  logic                 rst_n,
    input  logic                 tx_enable,
    input  logic                 tx_finite,
    input  logic [TX_CNT_W-1:0]  tx_count,
    input  logic [FLOW_ID_W-1:0] last_flow,
    input  logic                 flow_take,
    output logic [FLOW_ID_W-1:0] flow_id,
    output logic                 flow_valid
);

    logic                tx_enable_q;
    logic                id_stable;
    logic                start;
    logic                has_budget;
    logic [TX_CNT_W-1:0] budget;

    assign start      = tx_enable && !tx_enable_q;
    assign has_budget = !tx_finite || (budget != '0);

    // Offer only once the table read has caught up with flow_id
    assign flow_valid = tx_enable && tx_enable_q && id_stable && has_budget;

    always_ff @(posedge avmm_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            tx_enable_q <= 1'b0;
            id_stable   <= 1'b0;
            flow_id     <= '0;
            budget      <= '0;
        end else begin
            tx_enable_q <= tx_enable;
            id_stable   <= 1'b1;
            if (start) begin
                budget    <= tx_count;
                flow_id   <= '0;
                id_stable <= 1'b0;
            end else if (flow_take) begin
                flow_id   <= (flow_id >= last_flow) ? '0 : flow_id + 1'b1;
                id_stable <= 1'b0;
                if (tx_finite) begin
                    budget <= budget - 1'b1;
                end
            end
        end
    end

    // Round robin stays inside the programmed flow range
    assert property (@(posedge avmm_clk_ifc) disable iff (!rst_n)
        flow_valid |-> flow_id <= last_flow)
        else $error("flow_id %0d beyond last_flow %0d", flow_id, last_flow);

endmodule

//--- source/pktgen_framer.sv
// Frame builder, one flow definition into 8-byte stream beats
// with Ethernet header first and fill byte payload after
`timescale 1ns/1ps

module pktgen_framer
    import pktgen_pkg::*;
(
    input  logic                    avmm_clk_ifc,
    input  logic                    rst_n,
    input  logic                    flow_valid,
    input  logic [FLOW_ID_W-1:0]    flow_id,
    input  flow_def_t               flow_rd_data,
    output logic                    flow_take,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [8*BEAT_BYTES-1:0] out_data,
    output logic [BEAT_BYTES-1:0]   out_keep,
    output logic                    out_last,
    output logic [FLOW_ID_W-1:0]    out_user
);

    framer_state_e          state;
    flow_def_t              def_q;
    logic [FLOW_ID_W-1:0]   user_q;
    logic [8*HDR_BYTES-1:0] hdr_be;
    logic [7:0]             hdr_q [HDR_BYTES];
    logic [7:0]             fill_q;
    logic [LEN_W-1:0]       byte_pos;
    logic [LEN_W-1:0]       bytes_left;
    logic                   beat_acc;

    assign flow_take = (state == IDLE) && flow_valid;
    assign out_valid = (state == HEADER) || (state == PAYLOAD);
    assign out_last  = bytes_left <= LEN_W'(BEAT_BYTES);
    assign out_user  = user_q;
    assign beat_acc  = out_valid && out_ready;
    assign hdr_be    = {def_q.mac_da, def_q.mac_sa, def_q.ether_type};

    ////////////////////////////////////////
    // Packet FSM
    ////////////////////////////////////////

    always_ff @(posedge avmm_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            byte_pos   <= '0;
            bytes_left <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (flow_take) begin
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    byte_pos   <= '0;
                    bytes_left <= def_q.pkt_len;
                    state      <= HEADER;
                end
                HEADER, PAYLOAD: begin
                    if (beat_acc) begin
                        if (out_last) begin
                            state <= IDLE;
                        end else begin
                            byte_pos   <= byte_pos + LEN_W'(BEAT_BYTES);
                            bytes_left <= bytes_left - LEN_W'(BEAT_BYTES);
                            if (byte_pos + LEN_W'(BEAT_BYTES) >= LEN_W'(HDR_BYTES)) begin
                                state <= PAYLOAD;
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Definition latch and header byte order, MSB of DA goes first
    always_ff @(posedge avmm_clk_ifc) begin
        if (flow_take) begin
            def_q  <= flow_rd_data;
            user_q <= flow_id;
        end
        if (state == LOAD) begin
            for (int i = 0; i < HDR_BYTES; i++) begin
                hdr_q[i] <= hdr_be[8*(HDR_BYTES-1-i) +: 8];
            end
            fill_q <= def_q.payload_value;
        end
    end

    ////////////////////////////////////////
    // Beat assembly
    ////////////////////////////////////////

    always_comb begin
        logic [HDR_IDX_W-1:0] hdr_idx;
        out_data = '0;
        for (int b = 0; b < BEAT_BYTES; b++) begin
            hdr_idx     = byte_pos[HDR_IDX_W-1:0] + HDR_IDX_W'(b);
            out_keep[b] = bytes_left > LEN_W'(b);
            if (!out_keep[b]) begin
                out_data[8*b +: 8] = 8'h00;
            end else if ((state == HEADER) && (hdr_idx < HDR_IDX_W'(HDR_BYTES))) begin
                out_data[8*b +: 8] = hdr_q[hdr_idx];
            end else begin
                out_data[8*b +: 8] = fill_q;
            end
        end
    end

    // Stalled beat holds until the sink takes it
    assert property (@(posedge avmm_clk_ifc) disable iff (!rst_n)
        out_valid && !out_ready |=>
            out_valid && $stable(out_data) && $stable(out_keep) && $stable(out_last))
        else $error("stream beat changed under back-pressure");

endmodule

//--- source/pktgen_counters.sv
// Total packet and byte counters with snapshot on sample
`timescale 1ns/1ps

module pktgen_counters
    import pktgen_pkg::*;
(
    input  logic                  avmm_clk_ifc,
    input  logic                  rst_n,
    input  logic                  out_valid,
    input  logic                  out_ready,
    input  logic                  out_last,
    input  logic [BEAT_BYTES-1:0] out_keep,
    input  logic                  cnt_sample,
    output logic [CNT_W-1:0]      pkt_snap,
    output logic [CNT_W-1:0]      byte_snap
);

    logic [CNT_W-1:0] pkt_cnt;
    logic [CNT_W-1:0] byte_cnt;

    always_ff @(posedge avmm_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            pkt_cnt   <= '0;
            byte_cnt  <= '0;
            pkt_snap  <= '0;
            byte_snap <= '0;
        end else begin
            if (out_valid && out_ready) begin
                byte_cnt <= byte_cnt + CNT_W'($countones(out_keep));
                if (out_last) begin
                    pkt_cnt <= pkt_cnt + 1'b1;
                end
            end
            // Snapshot takes the live counts before this cycle's beat
            if (cnt_sample) begin
                pkt_snap  <= pkt_cnt;
                byte_snap <= byte_cnt;
            end
        end
    end

endmodule

//--- source/pktgen_top.sv
// Packet generator top level, registers, flow table, scheduler,
// framer and counters
`timescale 1ns/1ps

module pktgen_top
    import pktgen_pkg::*;
(
    input  logic                    avmm_clk_ifc,
    input  logic                    rst_n,
    input  logic [ADDR_W-1:0]       address,
    input  logic                    write,
    input  logic                    read,
    input  logic [DATA_W-1:0]       writedata,
    output logic [DATA_W-1:0]       readdata,
    output logic                    readdatavalid,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [8*BEAT_BYTES-1:0] out_data,
    output logic [BEAT_BYTES-1:0]   out_keep,
    output logic                    out_last,
    output logic [FLOW_ID_W-1:0]    out_user
);

    // Register block to datapath
    logic                 tx_enable;
    logic                 tx_finite;
    logic [TX_CNT_W-1:0]  tx_count;
    logic [FLOW_ID_W-1:0] last_flow;
    logic                 flow_wr;
    logic [FLOW_ID_W-1:0] flow_wr_id;
    flow_def_t            flow_wr_data;
    logic                 cnt_sample;
    logic [CNT_W-1:0]     pkt_snap;
    logic [CNT_W-1:0]     byte_snap;

    // Scheduler, table and framer
    logic [FLOW_ID_W-1:0] flow_id;
    logic                 flow_valid;
    logic                 flow_take;
    flow_def_t            flow_rd_data;

    pktgen_regs pktgen_regs_i (.*);

    pktgen_flow_table pktgen_flow_table_i (.*);

    pktgen_scheduler pktgen_scheduler_i (.*);

    pktgen_framer pktgen_framer_i (.*);

    pktgen_counters pktgen_counters_i (.*);

endmodule

//--- sim/pktgen_tb.sv
// Testbench for the packet generator with stream reference model,
// register readback and counter checks
`timescale 1ns/1ps

module pktgen_tb
    import pktgen_pkg::*;
();

    localparam int                   NUM_FLOWS    = 4;
    localparam logic [FLOW_ID_W-1:0] LAST_FLOW    = 4'd3;
    localparam int                   RUN_PKTS     = 12;
    localparam int                   CONT_PKTS    = 8;
    localparam int                   QUIET_CYCLES = 64;

    logic                    avmm_clk_ifc = 1'b0;
    logic                    rst_n;
    logic [ADDR_W-1:0]       address;
    logic                    write;
    logic                    read;
    logic [DATA_W-1:0]       writedata;
    logic [DATA_W-1:0]       readdata;
    logic                    readdatavalid;
    logic                    out_valid;
    logic                    out_ready;
    logic [8*BEAT_BYTES-1:0] out_data;
    logic [BEAT_BYTES-1:0]   out_keep;
    logic                    out_last;
    logic [FLOW_ID_W-1:0]    out_user;

    flow_def_t            defs [NUM_FLOWS];
    integer               seed        = 32'h885b;
    logic                 rand_ready  = 1'b0;
    logic                 expect_idle = 1'b0;
    logic [FLOW_ID_W-1:0] exp_flow    = '0;
    int                   beat_idx    = 0;
    int                   run_pkts    = 0;
    int                   run_bytes   = 0;
    int                   beats_seen  = 0;
    int                   errors      = 0;
    int                   cycles      = 0;
    int                   cycle_limit = 100000;
    logic [CNT_W-1:0]     tb_pkts     = '0;
    logic [CNT_W-1:0]     tb_bytes    = '0;

    pktgen_top pktgen_top_i (.*);

    always #4 avmm_clk_ifc = ~avmm_clk_ifc;

    ////////////////////////////////////////
    // Reference model and compare tasks
    ////////////////////////////////////////

    function automatic int flow_len(input int i);
        case (i)
            0:       return 64;
            1:       return 77;
            2:       return 130;
            default: return 199;
        endcase
    endfunction

    // Header goes out MSB first, fill byte after it, keep follows pkt_len
    function automatic logic [8*BEAT_BYTES-1:0] ref_beat(input flow_def_t f, input int beat,
            output logic [BEAT_BYTES-1:0] keep, output logic last);
        logic [8*HDR_BYTES-1:0]  hdr;
        logic [8*BEAT_BYTES-1:0] data;
        int                      idx;
        hdr  = {f.mac_da, f.mac_sa, f.ether_type};
        data = '0;
        keep = '0;
        for (int b = 0; b < BEAT_BYTES; b++) begin
            idx = beat * BEAT_BYTES + b;
            if (idx < int'(f.pkt_len)) begin
                keep[b] = 1'b1;
                if (idx < HDR_BYTES) begin
                    data[8*b +: 8] = hdr[8*(HDR_BYTES-1-idx) +: 8];
                end else begin
                    data[8*b +: 8] = f.payload_value;
                end
            end
        end
        last = ((beat + 1) * BEAT_BYTES) >= int'(f.pkt_len);
        return data;
    endfunction

    function automatic int total_beats();
        int per_round;
        per_round = 0;
        for (int i = 0; i < NUM_FLOWS; i++) begin
            per_round += (flow_len(i) + BEAT_BYTES - 1) / BEAT_BYTES;
        end
        return per_round * (2 * RUN_PKTS + CONT_PKTS + NUM_FLOWS) / NUM_FLOWS;
    endfunction

    task automatic check_beat(input logic [8*BEAT_BYTES-1:0] data,
            input logic [BEAT_BYTES-1:0] keep, input logic last,
            input logic [FLOW_ID_W-1:0] user, input logic [8*BEAT_BYTES-1:0] exp_data,
            input logic [BEAT_BYTES-1:0] exp_keep, input logic exp_last);
        logic [8*BEAT_BYTES-1:0] mask;
        for (int b = 0; b < BEAT_BYTES; b++) begin
            mask[8*b +: 8] = {8{exp_keep[b]}};
        end
        if (((data & mask) !== exp_data) || (keep !== exp_keep) || (last !== exp_last)
                || (user !== exp_flow)) begin
            errors++;
            $display("error @%0t: flow %0d beat %0d got %h/%h/%b/%0d, expected %h/%h/%b/%0d",
                $time, exp_flow, beat_idx, data, keep, last, user,
                exp_data, exp_keep, exp_last, exp_flow);
        end
    endtask

    task automatic check_word(input reg_addr_e a, input logic [DATA_W-1:0] got,
            input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error @%0t: %s read %h, expected %h", $time, a.name(), got, exp);
        end
    endtask

    task automatic check_count(input string what, input logic [CNT_W-1:0] got,
            input logic [CNT_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error @%0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // Stream monitor, ready and watchdog
    ////////////////////////////////////////

    always @(posedge avmm_clk_ifc) begin : monitor
        logic [8*BEAT_BYTES-1:0] exp_data;
        logic [BEAT_BYTES-1:0]   exp_keep;
        logic                    exp_last;
        if (rst_n && out_valid && expect_idle) begin
            errors++;
            $display("out_valid went high after transmission should have stopped");
        end
        if (rst_n && out_valid && out_ready) begin
            exp_data = ref_beat(defs[exp_flow], beat_idx, exp_keep, exp_last);
            check_beat(out_data, out_keep, out_last, out_user, exp_data, exp_keep, exp_last);
            beats_seen++;
            run_bytes += $countones(out_keep);
            tb_bytes  += CNT_W'($countones(exp_keep));
            if (exp_last) begin
                tb_pkts++;
            end
            if (out_last) begin
                run_pkts++;
                beat_idx = 0;
                exp_flow = (exp_flow == LAST_FLOW) ? '0 : exp_flow + 1'b1;
            end else begin
                beat_idx++;
            end
        end
    end

    always @(negedge avmm_clk_ifc) begin : ready_drive
        int r;
        r         = $random(seed);
        out_ready = rand_ready ? r[0] : 1'b1;
    end

    always @(posedge avmm_clk_ifc) begin : watchdog
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the DUT made no progress within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Control port tasks
    ////////////////////////////////////////

    task automatic ctrl_write(input reg_addr_e a, input logic [DATA_W-1:0] d);
        address   = a;
        writedata = d;
        write     = 1'b1;
        @(negedge avmm_clk_ifc);
        write     = 1'b0;
    endtask

    task automatic ctrl_read(input reg_addr_e a, output logic [DATA_W-1:0] d);
        address = a;
        read    = 1'b1;
        @(negedge avmm_clk_ifc);
        read    = 1'b0;
        if (!readdatavalid) begin
            errors++;
            $display("Read of %s gave no readdatavalid one cycle after the strobe", a.name());
        end
        d = readdata;
    endtask

    task automatic program_flow(input int i);
        logic [FLOW_DEF_WORDS*DATA_W-1:0] vec;
        vec = {defs[i], {(FLOW_DEF_WORDS*DATA_W-FLOW_DEF_BITS){1'b0}}};
        for (int w = 0; w < FLOW_DEF_WORDS; w++) begin
            ctrl_write(reg_addr_e'(ADDR_FLOW_DATA0 + w),
                vec[DATA_W*(FLOW_DEF_WORDS-1-w) +: DATA_W]);
        end
        ctrl_write(ADDR_FLOW_CON, {12'h000, LAST_FLOW, 4'h0, FLOW_ID_W'(i), 8'h01});
    endtask

    task automatic check_counters();
        logic [DATA_W-1:0] lo;
        logic [DATA_W-1:0] hi;
        ctrl_write(ADDR_CNTR_CON, 32'h1);
        // Snapshot lands one cycle after the pulse
        @(negedge avmm_clk_ifc);
        ctrl_read(ADDR_PKT_CNT0, lo);
        ctrl_read(ADDR_PKT_CNT1, hi);
        check_count("packet count", {hi, lo}, tb_pkts);
        ctrl_read(ADDR_BYTE_CNT0, lo);
        ctrl_read(ADDR_BYTE_CNT1, hi);
        check_count("byte count", {hi, lo}, tb_bytes);
    endtask

    task automatic quiet_window();
        expect_idle = 1'b1;
        repeat (QUIET_CYCLES) @(negedge avmm_clk_ifc);
        expect_idle = 1'b0;
    endtask

    task automatic start_run(input logic [DATA_W-1:0] tx_con, input logic random_ready);
        rand_ready = random_ready;
        run_pkts   = 0;
        run_bytes  = 0;
        exp_flow   = '0;
        // Enable has to rise again for the scheduler to load a budget
        ctrl_write(ADDR_TX_CON, 32'h0);
        ctrl_write(ADDR_TX_CON, tx_con);
    endtask

    task automatic run_finite(input logic random_ready);
        int exp_bytes;
        exp_bytes = 0;
        for (int i = 0; i < NUM_FLOWS; i++) begin
            exp_bytes += flow_len(i) * RUN_PKTS / NUM_FLOWS;
        end
        start_run({28'(RUN_PKTS), 4'b0011}, random_ready);
        while (run_pkts < RUN_PKTS) @(negedge avmm_clk_ifc);
        quiet_window();
        check_count("finite run packets", CNT_W'(run_pkts), CNT_W'(RUN_PKTS));
        check_count("finite run bytes", CNT_W'(run_bytes), CNT_W'(exp_bytes));
    endtask

    task automatic run_continuous();
        start_run(32'h1, 1'b1);
        while (run_pkts < CONT_PKTS) @(negedge avmm_clk_ifc);
        ctrl_write(ADDR_TX_CON, 32'h0);
        // A flow taken just before the clear shows out_valid two cycles later
        repeat (4) @(negedge avmm_clk_ifc);
        while (out_valid) @(negedge avmm_clk_ifc);
        if (beat_idx != 0) begin
            errors++;
            $display("Packet in flight stopped before its out_last beat");
        end
        quiet_window();
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin : stimulus
        logic [DATA_W-1:0] rd;
        rst_n     = 1'b0;
        address   = ADDR_ID;
        write     = 1'b0;
        read      = 1'b0;
        writedata = '0;
        out_ready = 1'b0;
        for (int i = 0; i < NUM_FLOWS; i++) begin
            defs[i].mac_da        = 48'h0200_0000_1000 + 48'(i);
            defs[i].mac_sa        = 48'h0200_0000_2000 + 48'(i);
            defs[i].ether_type    = 16'h88b5 + 16'(i);
            defs[i].pkt_len       = LEN_W'(flow_len(i));
            defs[i].payload_value = 8'ha0 + 8'(i);
        end
        cycle_limit = 4 * total_beats() + 2000;
        repeat (2) @(posedge avmm_clk_ifc);
        @(negedge avmm_clk_ifc);
        rst_n = 1'b1;
        @(negedge avmm_clk_ifc);

        if (out_valid) begin
            errors++;
            $display("out_valid is high right after reset");
        end
        ctrl_read(ADDR_ID, rd);
        check_word(ADDR_ID, rd, PKTGEN_ID);

        for (int i = 0; i < NUM_FLOWS; i++) begin
            program_flow(i);
        end
        run_finite(1'b0);
        check_counters();
        run_finite(1'b1);
        check_counters();
        run_continuous();
        check_counters();

        $display("Checked %0d beats and %0d packets, %0d errors", beats_seen, tb_pkts, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- pktgen.f
source/pktgen_pkg.sv
source/pktgen_regs.sv
source/pktgen_flow_table.sv
source/pktgen_scheduler.sv
source/pktgen_framer.sv
source/pktgen_counters.sv
source/pktgen_top.sv
sim/pktgen_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := pktgen_tb
RTL_TOP   := pktgen_top
FILELIST  := pktgen.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) source/pktgen_pkg.sv \
		source/pktgen_regs.sv source/pktgen_flow_table.sv source/pktgen_scheduler.sv \
		source/pktgen_framer.sv source/pktgen_counters.sv source/pktgen_top.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)
